// File: rtl/rv_pkg.sv
package rv_pkg;

   localparam int XLEN     = 32;
   localparam int NUM_REGS = 32;

   // Supported major opcodes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

   // ALU function codes
   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLL  = 3'b001;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_SR   = 3'b101;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   // Same instruction word seen as R-type or I-type
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm12;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
   } instr_u;

   typedef struct packed {
      logic [4:0]      rd;
      logic [4:0]      rs1;
      logic [4:0]      rs2;
      logic [2:0]      funct3;
      logic            alt;      // SUB or arithmetic shift
      logic            use_imm;
      logic [XLEN-1:0] imm;
      logic            writes;
      logic            illegal;
   } decoded_op_t;

   typedef struct packed {
      logic [4:0]      rd;
      logic [XLEN-1:0] value;
      logic            illegal;
   } wb_rec_t;

endpackage

// File: rtl/rv_decode.sv
`timescale 1ns/1ns

module rv_decode import rv_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        in_valid_i,
   output logic        in_ready_o,
   input  instr_u      instr_i,
   output logic        dec_valid_o,
   input  logic        dec_ready_i,
   output decoded_op_t dec_op_o
);

   decoded_op_t op_d;
   decoded_op_t op_q;
   logic        valid_q;

   always_comb begin
      op_d         = '0;
      op_d.rd      = instr_i.r.rd;
      op_d.rs1     = instr_i.r.rs1;
      op_d.funct3  = instr_i.r.funct3;
      case (instr_i.r.opcode)
         OPC_OP: begin
            op_d.rs2     = instr_i.r.rs2;
            op_d.alt     = instr_i.r.funct7[5];
            op_d.illegal = (instr_i.r.funct7 != 7'h00) && (instr_i.r.funct7 != 7'h20);
         end
         OPC_OP_IMM: begin
            op_d.use_imm = 1'b1;
            op_d.imm     = {{(XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
            // Shift amounts live in the low five bits, the rest is funct7
            if (instr_i.i.funct3 == F3_SLL) begin
               op_d.illegal = (instr_i.i.imm12[11:5] != 7'h00);
            end else if (instr_i.i.funct3 == F3_SR) begin
               op_d.alt     = instr_i.i.imm12[10];
               op_d.illegal = (instr_i.i.imm12[11:5] != 7'h00) &&
                              (instr_i.i.imm12[11:5] != 7'h20);
            end
         end
         default: begin
            op_d.illegal = 1'b1;
         end
      endcase
      op_d.writes = !op_d.illegal;
   end

   // One-entry stage register toward execute
   assign in_ready_o = !valid_q || dec_ready_i;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= 1'b0;
      end else if (in_ready_o) begin
         valid_q <= in_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid_i && in_ready_o) begin
         op_q <= op_d;
      end
   end

   assign dec_valid_o = valid_q;
   assign dec_op_o    = op_q;

endmodule

// File: rtl/rv_reg_file.sv
`timescale 1ns/1ns

module rv_reg_file import rv_pkg::*; (
   input  logic            clk,
   input  logic            reset,
   input  logic [4:0]      rs1_i,
   input  logic [4:0]      rs2_i,
   output logic [XLEN-1:0] rdata1_o,
   output logic [XLEN-1:0] rdata2_o,
   input  logic            we_i,
   input  logic [4:0]      waddr_i,
   input  logic [XLEN-1:0] wdata_i
);

   logic [XLEN-1:0] regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int k = 0; k < NUM_REGS; k++) begin
            regs[k] <= '0;
         end
      end else if (we_i && (waddr_i != 5'd0)) begin
         regs[waddr_i] <= wdata_i;
      end
   end

   // x0 is hardwired
   assign rdata1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
   assign rdata2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

// File: rtl/rv_forward.sv
`timescale 1ns/1ns

module rv_forward import rv_pkg::*; (
   input  logic [4:0]      rs1_i,
   input  logic [4:0]      rs2_i,
   input  logic [XLEN-1:0] rdata1_i,
   input  logic [XLEN-1:0] rdata2_i,
   input  logic            wb_valid_i,
   input  wb_rec_t         wb_rec_i,
   input  logic            wb_writes_i,
   output logic [XLEN-1:0] op1_o,
   output logic [XLEN-1:0] op2_o
);

   logic pending;

   // The held record has not reached the register file yet
   assign pending = wb_valid_i && wb_writes_i && (wb_rec_i.rd != 5'd0);

   function automatic logic [XLEN-1:0] pick(
      input logic [4:0]      rs,
      input logic [XLEN-1:0] rdata,
      input logic            hit_ok,
      input wb_rec_t         rec
   );
      logic hit;
      hit = hit_ok && (rec.rd == rs);
      return hit ? rec.value : rdata;
   endfunction

   assign op1_o = pick(rs1_i, rdata1_i, pending, wb_rec_i);
   assign op2_o = pick(rs2_i, rdata2_i, pending, wb_rec_i);

endmodule

// File: rtl/rv_execute.sv
`timescale 1ns/1ns

module rv_execute import rv_pkg::*; (
   input  logic            clk,
   input  logic            reset,
   input  logic            dec_valid_i,
   output logic            dec_ready_o,
   input  decoded_op_t     dec_op_i,
   input  logic [XLEN-1:0] op1_i,
   input  logic [XLEN-1:0] op2_i,
   output logic            out_valid_o,
   input  logic            out_ready_i,
   output wb_rec_t         out_rec_o,
   output logic            wb_writes_o
);

   logic [XLEN-1:0] b;
   logic [4:0]      shamt;
   logic [XLEN-1:0] result;
   wb_rec_t         rec_d;
   wb_rec_t         rec_q;
   logic            writes_q;
   logic            valid_q;

   assign b     = dec_op_i.use_imm ? dec_op_i.imm : op2_i;
   assign shamt = b[4:0];

   always_comb begin
      case (dec_op_i.funct3)
         F3_ADD:  result = dec_op_i.alt ? (op1_i - b) : (op1_i + b);
         F3_SLL:  result = op1_i << shamt;
         F3_SLT:  result = {{(XLEN-1){1'b0}}, ($signed(op1_i) < $signed(b))};
         F3_SLTU: result = {{(XLEN-1){1'b0}}, (op1_i < b)};
         F3_XOR:  result = op1_i ^ b;
         F3_SR:   result = dec_op_i.alt ? $unsigned($signed(op1_i) >>> shamt) : (op1_i >> shamt);
         F3_OR:   result = op1_i | b;
         default: result = op1_i & b;
      endcase
   end

   always_comb begin
      rec_d.rd      = dec_op_i.rd;
      rec_d.value   = dec_op_i.illegal ? '0 : result;
      rec_d.illegal = dec_op_i.illegal;
   end

   // Writeback register filled when empty or draining
   assign dec_ready_o = !valid_q || out_ready_i;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= 1'b0;
      end else if (dec_ready_o) begin
         valid_q <= dec_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (dec_valid_i && dec_ready_o) begin
         rec_q    <= rec_d;
         writes_q <= dec_op_i.writes;
      end
   end

   assign out_valid_o = valid_q;
   assign out_rec_o   = rec_q;
   assign wb_writes_o = writes_q;

endmodule

// File: rtl/rv_core.sv
`timescale 1ns/1ns

module rv_core import rv_pkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  logic    in_valid_i,
   output logic    in_ready_o,
   input  instr_u  instr_i,
   output logic    out_valid_o,
   input  logic    out_ready_i,
   output wb_rec_t out_rec_o
);

   logic            dec_valid;
   logic            dec_ready;
   decoded_op_t     dec_op;
   logic [XLEN-1:0] rdata1;
   logic [XLEN-1:0] rdata2;
   logic [XLEN-1:0] op1;
   logic [XLEN-1:0] op2;
   logic            wb_writes;
   logic            rf_we;

   rv_decode u_decode (
      .clk         (clk),
      .reset       (reset),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .instr_i     (instr_i),
      .dec_valid_o (dec_valid),
      .dec_ready_i (dec_ready),
      .dec_op_o    (dec_op)
   );

   // Retire into the register file on the output transfer
   assign rf_we = out_valid_o && out_ready_i && wb_writes;

   rv_reg_file u_reg_file (
      .clk      (clk),
      .reset    (reset),
      .rs1_i    (dec_op.rs1),
      .rs2_i    (dec_op.rs2),
      .rdata1_o (rdata1),
      .rdata2_o (rdata2),
      .we_i     (rf_we),
      .waddr_i  (out_rec_o.rd),
      .wdata_i  (out_rec_o.value)
   );

   rv_forward u_forward (
      .rs1_i       (dec_op.rs1),
      .rs2_i       (dec_op.rs2),
      .rdata1_i    (rdata1),
      .rdata2_i    (rdata2),
      .wb_valid_i  (out_valid_o),
      .wb_rec_i    (out_rec_o),
      .wb_writes_i (wb_writes),
      .op1_o       (op1),
      .op2_o       (op2)
   );

   rv_execute u_execute (
      .clk         (clk),
      .reset       (reset),
      .dec_valid_i (dec_valid),
      .dec_ready_o (dec_ready),
      .dec_op_i    (dec_op),
      .op1_i       (op1),
      .op2_i       (op2),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i),
      .out_rec_o   (out_rec_o),
      .wb_writes_o (wb_writes)
   );

endmodule

// File: tb/rv_properties.sv
`timescale 1ns/1ns

module rv_properties import rv_pkg::*; (
   input logic    clk,
   input logic    reset,
   input logic    out_valid_i,
   input logic    out_ready_i,
   input wb_rec_t out_rec_i
);

   int fail_count = 0;

   assert property (@(posedge clk) disable iff (reset)
      out_valid_i && !out_ready_i |=> out_valid_i)
   else begin
      fail_count++;
      $error("out_valid dropped before the record was taken");
   end

   // Held record must not change while stalled
   assert property (@(posedge clk) disable iff (reset)
      out_valid_i && !out_ready_i |=> $stable(out_rec_i))
   else begin
      fail_count++;
      $error("out_rec changed while stalled");
   end

   assert property (@(posedge clk) reset |=> !out_valid_i)
   else begin
      fail_count++;
      $error("out_valid high after reset");
   end

endmodule

bind rv_execute rv_properties u_props (
   .clk         (clk),
   .reset       (reset),
   .out_valid_i (out_valid_o),
   .out_ready_i (out_ready_i),
   .out_rec_i   (out_rec_o)
);

// File: tb/rv_monitor.sv
`timescale 1ns/1ns

module rv_monitor import rv_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        in_valid_i,
   input  logic        in_ready_i,
   input  logic [31:0] instr_i,
   input  logic        out_valid_i,
   input  logic        out_ready_i,
   input  wb_rec_t     out_rec_i,
   output int          accepted_o,
   output int          retired_o,
   output int          errors_o
);

   logic [XLEN-1:0] model [NUM_REGS];
   logic [31:0]     words [$];
   int              stamps [$];
   int              cycle = 0;
   int              last_stall = 0;

   function automatic wb_rec_t expect_rec(input logic [31:0] w);
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      logic [XLEN-1:0] v;
      logic            is_op;
      logic            ok;
      wb_rec_t         rec;
      is_op = (w[6:0] == OPC_OP);
      a     = model[w[19:15]];
      b     = is_op ? model[w[24:20]] : {{20{w[31]}}, w[31:20]};
      if (is_op || w[14:12] == 3'd5) begin
         ok = (w[31:25] == 7'h00) || (w[31:25] == 7'h20);
      end else begin
         ok = (w[14:12] != 3'd1) || (w[31:25] == 7'h00);
      end
      ok = ok && (is_op || w[6:0] == OPC_OP_IMM);
      case (w[14:12])
         3'd0:    v = (is_op && w[30]) ? a - b : a + b;
         3'd1:    v = a << b[4:0];
         3'd2:    v = {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
         3'd3:    v = {31'd0, a < b};
         3'd4:    v = a ^ b;
         // Arithmetic shift fills the vacated top bits with the sign
         3'd5:    v = (a >> b[4:0]) | ((w[30] && a[31]) ? ~({XLEN{1'b1}} >> b[4:0]) : '0);
         3'd6:    v = a | b;
         default: v = a & b;
      endcase
      rec.rd      = w[11:7];
      rec.value   = ok ? v : '0;
      rec.illegal = !ok;
      return rec;
   endfunction

   always @(posedge clk) begin
      wb_rec_t want;
      if (reset) begin
         foreach (model[k]) model[k] = '0;
         words.delete();
         stamps.delete();
      end else begin
         if (out_valid_i && out_ready_i) begin
            if (words.size() == 0) begin
               errors_o++;
               $display("Output record at %0t has no matching input instruction", $time);
            end else begin
               want = expect_rec(words[0]);
               if (out_rec_i !== want) begin
                  errors_o++;
                  $display("FAILED at %0t: word %h gave rd %0d value %h illegal %b, %s %0d %h %b",
                           $time, words[0], out_rec_i.rd, out_rec_i.value, out_rec_i.illegal,
                           "expected", want.rd, want.value, want.illegal);
               end
               if (cycle - stamps[0] < 2 || (last_stall <= stamps[0] && cycle - stamps[0] != 2))
               begin
                  errors_o++;
                  $display("FAILED at %0t: word %h took %0d cycles, expected 2",
                           $time, words[0], cycle - stamps[0]);
               end
               if (!want.illegal && want.rd != 5'd0) begin
                  model[want.rd] = want.value;
               end
               void'(words.pop_front());
               void'(stamps.pop_front());
               retired_o++;
            end
         end
         if (in_valid_i && in_ready_i) begin
            words.push_back(instr_i);
            stamps.push_back(cycle);
            accepted_o++;
         end
         if (!out_ready_i) begin
            last_stall = cycle;
         end
      end
      cycle++;
   end

endmodule

// File: tb/rv_tb.sv
`timescale 1ns/1ns

module rv_tb import rv_pkg::*; ();

   localparam int          NUM_INSTR    = 600;
   localparam int          STEADY_INSTR = 150;
   localparam int          RESET_CYCLES = 8;
   localparam int          TIMEOUT      = NUM_INSTR * 8 + 100;
   localparam logic [31:0] SEED         = 32'd69949;

   logic        clk;
   logic        reset;
   logic        in_valid;
   logic        in_ready;
   logic [31:0] instr_word;
   logic        out_valid;
   logic        out_ready;
   wb_rec_t     out_rec;
   int          accepted;
   int          retired;
   int          errors;
   int          assert_fails;
   int          sent;
   int          cycles = 0;
   logic [31:0] lfsr;

   initial clk = 1'b0;
   always #2 clk = ~clk;

   function automatic logic next_bit();
      logic b;
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
         lfsr = lfsr ^ 32'h80200003;
      end
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v = {v[30:0], next_bit()};
      end
      return v;
   endfunction

   // Registers limited to x0..x7 so hazards come up often
   function automatic logic [31:0] make_instr();
      logic [3:0]  kind;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [2:0]  f3;
      logic        alt;
      logic [11:0] imm;
      logic [6:0]  f7;
      logic [31:0] w;
      kind = 4'(rand_bits(4));
      rd   = 5'(rand_bits(3));
      rs1  = 5'(rand_bits(3));
      rs2  = 5'(rand_bits(3));
      f3   = 3'(rand_bits(3));
      alt  = next_bit();
      imm  = 12'(rand_bits(12));
      f7   = 7'(rand_bits(7));
      if (kind < 4'd7) begin
         if (f3 == 3'd1) begin
            imm[11:5] = 7'h00;
         end else if (f3 == 3'd5) begin
            imm[11:5] = alt ? 7'h20 : 7'h00;
         end
         w = {imm, rs1, f3, rd, OPC_OP_IMM};
      end else if (kind < 4'd13) begin
         w = {(alt ? 7'h20 : 7'h00), rs2, rs1, f3, rd, OPC_OP};
      end else if (kind == 4'd13) begin
         w = rand_bits(32);
         if (w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM) begin
            w[6:0] = 7'b0000011;
         end
      end else if (kind == 4'd14) begin
         if (f7 == 7'h00 || f7 == 7'h20) begin
            f7 = 7'h01;
         end
         w = {f7, rs2, rs1, f3, rd, OPC_OP};
      end else begin
         // Shift immediate with a bad upper field
         if (f7 == 7'h00 || f7 == 7'h20) begin
            f7 = 7'h40;
         end
         w = {f7, imm[4:0], rs1, (alt ? 3'd5 : 3'd1), rd, OPC_OP_IMM};
      end
      return w;
   endfunction

   rv_core UUT (
      .clk         (clk),
      .reset       (reset),
      .in_valid_i  (in_valid),
      .in_ready_o  (in_ready),
      .instr_i     (instr_word),
      .out_valid_o (out_valid),
      .out_ready_i (out_ready),
      .out_rec_o   (out_rec)
   );

   rv_monitor u_monitor (
      .clk         (clk),
      .reset       (reset),
      .in_valid_i  (in_valid),
      .in_ready_i  (in_ready),
      .instr_i     (instr_word),
      .out_valid_i (out_valid),
      .out_ready_i (out_ready),
      .out_rec_i   (out_rec),
      .accepted_o  (accepted),
      .retired_o   (retired),
      .errors_o    (errors)
   );

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT) begin
         $display("Timeout: only %0d of %0d records retired after %0d cycles",
                  retired, NUM_INSTR, cycles);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   initial begin
      logic took;
      lfsr       = SEED;
      reset      = 1'b1;
      in_valid   = 1'b0;
      instr_word = '0;
      out_ready  = 1'b0;
      sent       = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 reset = 1'b0;
      // Steady phase first, then random gaps and back-pressure
      while (sent < NUM_INSTR) begin
         @(posedge clk);
         took = in_valid && in_ready;
         if (took) begin
            sent++;
         end
         #1;
         out_ready = (sent < STEADY_INSTR) ? 1'b1 : next_bit();
         if (took || !in_valid) begin
            if (sent >= NUM_INSTR) begin
               in_valid = 1'b0;
            end else if (sent < STEADY_INSTR) begin
               in_valid = 1'b1;
            end else begin
               in_valid = (rand_bits(2) != 0);
            end
            if (in_valid) begin
               instr_word = make_instr();
            end
         end
      end
      out_ready = 1'b1;
      wait (retired == NUM_INSTR);
      repeat (8) @(posedge clk);
      #1;
      assert_fails = UUT.u_execute.u_props.fail_count;
      if (accepted != retired) begin
         $display("Output count %0d does not match input count %0d", retired, accepted);
      end
      $display("Sent %0d, accepted %0d, retired %0d, check errors %0d, assertion failures %0d",
               sent, accepted, retired, errors, assert_fails);
      if (errors == 0 && assert_fails == 0 && accepted == NUM_INSTR && retired == NUM_INSTR)
      begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: list.f
rtl/rv_pkg.sv
rtl/rv_decode.sv
rtl/rv_reg_file.sv
rtl/rv_forward.sv
rtl/rv_execute.sv
rtl/rv_core.sv
tb/rv_properties.sv
tb/rv_monitor.sv
tb/rv_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - rtl/rv_pkg.sv
  - rtl/rv_decode.sv
  - rtl/rv_reg_file.sv
  - rtl/rv_forward.sv
  - rtl/rv_execute.sv
  - rtl/rv_core.sv
  - target: test
    files:
      - tb/rv_properties.sv
      - tb/rv_monitor.sv
      - tb/rv_tb.sv
